/* src/tisPkg.sv */
// TPM TIS register block shared definitions
// Register map, command FSM states and the decoded host access
package tisPkg;

  localparam int NUM_LOCALITIES = 5;
  localparam logic [3:0] LOCALITY_NONE = 4'hF;
  localparam int RAM_ADDR_W = 11;   // 2 KiB command/response buffer
  localparam int HDR_BYTES = 6;     // Tag, then the 4-byte big-endian size

  // Register offsets within one locality, each register spans four bytes
  localparam logic [11:0] REG_OFS_ACCESS     = 12'h000;
  localparam logic [11:0] REG_OFS_INT_ENABLE = 12'h008;
  localparam logic [11:0] REG_OFS_INT_VECTOR = 12'h00C;
  localparam logic [11:0] REG_OFS_INT_STATUS = 12'h010;
  localparam logic [11:0] REG_OFS_STS        = 12'h018;
  localparam logic [11:0] REG_OFS_DATA_FIFO  = 12'h024;

  typedef enum logic [2:0] {
    REG_ACCESS,
    REG_INT_ENABLE,
    REG_INT_VECTOR,
    REG_INT_STATUS,
    REG_STS,
    REG_DATA_FIFO,
    REG_NONE
  } regId_e;

  // Low 3 bits count header bytes in the RX and TX groups
  typedef enum logic [4:0] {
    ST_IDLE    = 5'b00000,
    ST_READY   = 5'b00001,
    ST_EXEC    = 5'b00010,
    ST_RX_HDR0 = 5'b01000,
    ST_RX_HDR1 = 5'b01001,
    ST_RX_HDR2 = 5'b01010,
    ST_RX_HDR3 = 5'b01011,
    ST_RX_HDR4 = 5'b01100,
    ST_RX_HDR5 = 5'b01101,
    ST_RX_BODY = 5'b01110,
    ST_RX_LAST = 5'b01111,
    ST_TX_HDR0 = 5'b10000,
    ST_TX_HDR1 = 5'b10001,
    ST_TX_HDR2 = 5'b10010,
    ST_TX_HDR3 = 5'b10011,
    ST_TX_HDR4 = 5'b10100,
    ST_TX_HDR5 = 5'b10101,
    ST_TX_BODY = 5'b10110,
    ST_TX_LAST = 5'b10111
  } cmdState_e;

  typedef struct packed {
    logic       rdStb;     // One cycle per host read
    logic       wrStb;     // One cycle per host write
    regId_e     regId;
    logic [1:0] byteSel;
    logic [3:0] locality;
    logic [7:0] wrData;
  } busReq_t;

endpackage

/* src/tisBusPort.sv */
// TIS host bus port
// Four-phase byte handshake, address decode and the registered read byte
`timescale 1ns/1ps

module tisBusPort (
  input  logic            clk_i,
  input  logic            rstN_i,
  input  logic            dataReq_i,
  input  logic            dataWr_i,
  input  logic [15:0]     addr_i,
  input  logic [7:0]      data_i,
  input  logic [7:0]      accessRd_i,
  input  logic [7:0]      intRd_i,
  input  logic [7:0]      cmdRd_i,
  output tisPkg::busReq_t req_o,
  output logic [7:0]      data_o,
  output logic            dataRd_o,
  output logic            wrDone_o
);
  import tisPkg::*;

  logic [7:0] rdByte;

  always_comb begin
    req_o.rdStb    = dataReq_i && !dataRd_o;
    req_o.wrStb    = dataWr_i && !wrDone_o && !req_o.rdStb;  // Reads win a tie
    req_o.byteSel  = addr_i[1:0];
    req_o.locality = addr_i[15:12];
    req_o.wrData   = data_i;
    case (addr_i[11:2])
      REG_OFS_ACCESS[11:2]:     req_o.regId = REG_ACCESS;
      REG_OFS_INT_ENABLE[11:2]: req_o.regId = REG_INT_ENABLE;
      REG_OFS_INT_VECTOR[11:2]: req_o.regId = REG_INT_VECTOR;
      REG_OFS_INT_STATUS[11:2]: req_o.regId = REG_INT_STATUS;
      REG_OFS_STS[11:2]:        req_o.regId = REG_STS;
      REG_OFS_DATA_FIFO[11:2]:  req_o.regId = REG_DATA_FIFO;
      default:                  req_o.regId = REG_NONE;
    endcase
    if (addr_i[15:12] >= 4'(NUM_LOCALITIES)) req_o.regId = REG_NONE;
  end

  always_comb begin
    case (req_o.regId)
      REG_ACCESS:                                     rdByte = accessRd_i;
      REG_INT_ENABLE, REG_INT_VECTOR, REG_INT_STATUS: rdByte = intRd_i;
      REG_STS, REG_DATA_FIFO:                         rdByte = cmdRd_i;
      default:                                        rdByte = 8'hFF;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      data_o   <= 8'hFF;
      dataRd_o <= 1'b0;
      wrDone_o <= 1'b0;
    end else begin
      if (req_o.rdStb) begin
        data_o   <= rdByte;
        dataRd_o <= 1'b1;
      end else if (!dataReq_i) begin
        dataRd_o <= 1'b0;
      end
      if (req_o.wrStb) wrDone_o <= 1'b1;
      else if (!dataWr_i) wrDone_o <= 1'b0;  // Release once the host drops its write
    end
  end

endmodule

/* src/tisLocalityArb.sv */
// TIS locality arbitration
// TPM_ACCESS per-locality state, seize and relinquish hand-over
`timescale 1ns/1ps

module tisLocalityArb (
  input  logic            clk_i,
  input  logic            rstN_i,
  input  tisPkg::busReq_t req_i,
  output logic [3:0]      activeLocality_o,
  output logic            localityMatch_o,
  output logic [7:0]      accessRd_o,
  output logic            localityChange_o,
  output logic            cmdAbort_o
);
  import tisPkg::*;

  logic [NUM_LOCALITIES-1:0] requestUse;
  logic [NUM_LOCALITIES-1:0] beenSeized;
  logic [NUM_LOCALITIES-1:0] locHot;
  logic [NUM_LOCALITIES-1:0] activeHot;
  logic [NUM_LOCALITIES-1:0] nextHot;
  logic [3:0]                activeLocality;
  logic [3:0]                nextOwner;
  logic                      accessWr;
  logic                      noOwner;

  // One-hot masks, a shift by LOCALITY_NONE yields zero
  assign locHot    = NUM_LOCALITIES'(1) << req_i.locality;
  assign activeHot = NUM_LOCALITIES'(1) << activeLocality;
  assign nextHot   = NUM_LOCALITIES'(1) << nextOwner;

  // Highest requesting locality takes over on a relinquish
  always_comb begin
    nextOwner = LOCALITY_NONE;
    for (int i = 0; i < NUM_LOCALITIES; i++) begin
      if (requestUse[i]) nextOwner = 4'(i);
    end
  end

  assign noOwner          = activeLocality == LOCALITY_NONE;
  assign localityMatch_o  = req_i.locality == activeLocality;
  assign activeLocality_o = activeLocality;
  assign accessWr = req_i.wrStb && req_i.regId == REG_ACCESS && req_i.byteSel == 2'd0;

  assign accessRd_o = (req_i.byteSel != 2'd0) ? 8'h00 :
                      {1'b1, 1'b0, localityMatch_o, |(beenSeized & locHot), 1'b0,
                       |(requestUse & ~locHot), |(requestUse & locHot), 1'b0};

  // Lowest set bit of the written byte decides the action
  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      activeLocality   <= LOCALITY_NONE;
      requestUse       <= '0;
      beenSeized       <= '0;
      localityChange_o <= 1'b0;
      cmdAbort_o       <= 1'b0;
    end else begin
      localityChange_o <= 1'b0;
      cmdAbort_o       <= 1'b0;
      if (accessWr) begin
        if (req_i.wrData[1]) begin                       // requestUse
          if (noOwner) activeLocality <= req_i.locality;
          else if (!localityMatch_o) requestUse <= requestUse | locHot;
        end else if (req_i.wrData[3]) begin              // Seize
          if (noOwner) begin
            activeLocality <= req_i.locality;
          end else if (req_i.locality > activeLocality) begin
            activeLocality   <= req_i.locality;
            requestUse       <= requestUse & ~locHot;
            beenSeized       <= beenSeized | activeHot;
            localityChange_o <= |(requestUse & locHot);
            cmdAbort_o       <= 1'b1;
          end
        end else if (req_i.wrData[4]) begin              // Clear beenSeized
          beenSeized <= beenSeized & ~locHot;
        end else if (req_i.wrData[5]) begin              // Relinquish
          if (localityMatch_o) begin
            activeLocality   <= nextOwner;
            requestUse       <= requestUse & ~nextHot;
            localityChange_o <= nextOwner != LOCALITY_NONE;
            cmdAbort_o       <= 1'b1;
          end else begin
            requestUse <= requestUse & ~locHot;  // Withdraw a pending request
          end
        end
      end
    end
  end

endmodule

/* src/tisIntCtrl.sv */
// TIS interrupt control
// Enable, vector and status registers for dataAvail and localityChange
`timescale 1ns/1ps

module tisIntCtrl (
  input  logic            clk_i,
  input  logic            rstN_i,
  input  tisPkg::busReq_t req_i,
  input  logic            localityMatch_i,
  input  logic            localityChange_i,
  input  logic            dataAvailSet_i,
  output logic [7:0]      intRd_o,
  output logic [3:0]      irqNum_o,
  output logic            interrupt_o
);
  import tisPkg::*;

  logic       dataAvailEn;
  logic       locChangeEn;
  logic       globalEn;
  logic [3:0] vector;
  logic       dataAvailSts;
  logic       locChangeSts;
  logic       armed;
  logic       ownerWr;

  assign armed       = globalEn && |vector;
  assign ownerWr     = req_i.wrStb && localityMatch_i;
  assign irqNum_o    = vector;
  assign interrupt_o = armed && (dataAvailSts || locChangeSts);

  always_comb begin
    intRd_o = 8'h00;
    case (req_i.regId)
      REG_INT_ENABLE: begin
        if (req_i.byteSel == 2'd0) intRd_o = {3'b000, 2'b01, locChangeEn, 1'b0, dataAvailEn};
        if (req_i.byteSel == 2'd3) intRd_o = {globalEn, 7'h00};
      end
      REG_INT_VECTOR: if (req_i.byteSel == 2'd0) intRd_o = {4'h0, vector};
      REG_INT_STATUS: if (req_i.byteSel == 2'd0) intRd_o = {5'b0, locChangeSts, 1'b0, dataAvailSts};
      default: intRd_o = 8'hFF;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      dataAvailEn  <= 1'b0;
      locChangeEn  <= 1'b0;
      globalEn     <= 1'b0;
      vector       <= 4'h0;
      dataAvailSts <= 1'b0;
      locChangeSts <= 1'b0;
    end else begin
      if (ownerWr && req_i.byteSel == 2'd0) begin
        case (req_i.regId)
          REG_INT_ENABLE: begin
            dataAvailEn <= req_i.wrData[0];
            locChangeEn <= req_i.wrData[2];
          end
          REG_INT_VECTOR: vector <= req_i.wrData[3:0];
          REG_INT_STATUS: begin  // Write 1 to clear
            if (req_i.wrData[0]) dataAvailSts <= 1'b0;
            if (req_i.wrData[2]) locChangeSts <= 1'b0;
          end
          default: ;
        endcase
      end
      if (ownerWr && req_i.regId == REG_INT_ENABLE && req_i.byteSel == 2'd3)
        globalEn <= req_i.wrData[7];
      // A new event wins over a clear in the same cycle
      if (dataAvailSet_i && dataAvailEn && armed) dataAvailSts <= 1'b1;
      if (localityChange_i && locChangeEn && armed) locChangeSts <= 1'b1;
    end
  end

endmodule

/* src/tisCmdFifo.sv */
// TIS command FIFO engine
// TPM_STS and TPM_DATA_FIFO state machine with the byte-wide RAM port
`timescale 1ns/1ps

module tisCmdFifo (
  input  logic                          clk_i,
  input  logic                          rstN_i,
  input  tisPkg::busReq_t               req_i,
  input  logic                          localityMatch_i,
  input  logic                          cmdAbort_i,
  output logic [7:0]                    cmdRd_o,
  output logic                          dataAvailSet_o,
  output logic                          exec_o,
  input  logic                          complete_i,
  output logic                          abort_o,
  output logic [tisPkg::RAM_ADDR_W-1:0] ramAddr_o,
  input  logic [7:0]                    ramRdData_i,
  output logic [7:0]                    ramWrData_o,
  output logic                          ramWr_o,
  output logic                          ramRd_o
);
  import tisPkg::*;

  cmdState_e   state;
  cmdState_e   stepState;
  logic [31:0] fifoLeft;
  logic [31:0] stepLeft;
  logic [7:0]  xferByte;
  logic        lastByte;
  logic        expectByte;
  logic        dataAvail;
  logic        commandReady;
  logic        inTx;
  logic        readable;
  logic        stsWr;
  logic        fifoWr;
  logic        fifoRd;
  logic        abortReq;

  assign inTx     = state inside {[ST_TX_HDR0:ST_TX_LAST]};
  assign readable = localityMatch_i && dataAvail && inTx && state != ST_TX_LAST;
  assign stsWr    = req_i.wrStb && req_i.regId == REG_STS && localityMatch_i &&
                    req_i.byteSel == 2'd0;
  assign fifoWr   = req_i.wrStb && req_i.regId == REG_DATA_FIFO && localityMatch_i &&
                    expectByte;
  assign fifoRd   = req_i.rdStb && req_i.regId == REG_DATA_FIFO && readable;
  assign abortReq = stsWr && req_i.wrData[6] && state != ST_IDLE;  // commandReady mid-command
  assign ramRd_o  = ~ramWr_o;

  // Header walk and length countdown, shared by reception and completion
  always_comb begin
    xferByte  = inTx ? ramRdData_i : req_i.wrData;
    stepState = (state == ST_READY) ? ST_RX_HDR1 : cmdState_e'(state + 5'd1);
    stepLeft  = fifoLeft;
    lastByte  = 1'b0;
    case (state[2:0])
      3'd2: stepLeft[31:24] = xferByte;
      3'd3: stepLeft[23:16] = xferByte;
      3'd4: stepLeft[15:8]  = xferByte;
      3'd5: stepLeft = {fifoLeft[31:8], xferByte} - 32'(HDR_BYTES + 1);
      3'd6: begin
        stepLeft = fifoLeft - 32'd1;
        lastByte = fifoLeft == 32'd0;
        if (!lastByte) stepState = state;
      end
      default: ;
    endcase
  end

  always_comb begin
    cmdRd_o = 8'hFF;
    if (localityMatch_i) begin
      if (req_i.regId == REG_STS) begin
        case (req_i.byteSel)
          2'd0:    cmdRd_o = {1'b1, commandReady, 1'b0, dataAvail, expectByte, 3'b000};
          2'd1:    cmdRd_o = 8'h01;     // Static burst count
          default: cmdRd_o = 8'h00;
        endcase
      end else if (req_i.regId == REG_DATA_FIFO && readable) begin
        cmdRd_o = ramRdData_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifoWr) ramWrData_o <= req_i.wrData;
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      state          <= ST_IDLE;
      fifoLeft       <= '0;
      expectByte     <= 1'b0;
      dataAvail      <= 1'b0;
      commandReady   <= 1'b0;
      exec_o         <= 1'b0;
      abort_o        <= 1'b0;
      dataAvailSet_o <= 1'b0;
      ramAddr_o      <= '1;
      ramWr_o        <= 1'b0;
    end else begin
      ramWr_o        <= 1'b0;
      dataAvailSet_o <= 1'b0;
      if (cmdAbort_i || abortReq) begin
        state        <= ST_IDLE;
        fifoLeft     <= '0;
        expectByte   <= 1'b0;
        dataAvail    <= 1'b0;
        commandReady <= 1'b0;
        exec_o       <= 1'b0;
        abort_o      <= state != ST_TX_LAST;  // Normal end after the last byte
        ramAddr_o    <= '1;   // Next write lands at 0
      end else if (exec_o && complete_i) begin
        exec_o         <= 1'b0;
        state          <= ST_TX_HDR0;
        dataAvail      <= 1'b1;
        dataAvailSet_o <= !dataAvail;
      end else if (stsWr) begin
        if (state == ST_IDLE && req_i.wrData[6]) begin
          state        <= ST_READY;
          expectByte   <= 1'b1;
          commandReady <= 1'b1;
          abort_o      <= 1'b0;
        end else if (state == ST_RX_LAST && req_i.wrData[5]) begin  // tpmGo
          state     <= ST_EXEC;
          exec_o    <= 1'b1;
          ramAddr_o <= '0;
        end else if (inTx && req_i.wrData[1]) begin                 // responseRetry
          state          <= ST_TX_HDR0;
          ramAddr_o      <= '0;
          dataAvail      <= 1'b1;
          dataAvailSet_o <= !dataAvail;
        end
      end else if (fifoWr) begin
        ramAddr_o    <= ramAddr_o + 1'b1;
        ramWr_o      <= 1'b1;
        state        <= stepState;
        fifoLeft     <= stepLeft;
        commandReady <= 1'b0;
        if (lastByte) expectByte <= 1'b0;
      end else if (fifoRd) begin
        ramAddr_o <= ramAddr_o + 1'b1;
        state     <= stepState;
        fifoLeft  <= stepLeft;
        if (lastByte) dataAvail <= 1'b0;
      end
    end
  end

endmodule

/* src/tisRegs.sv */
// TPM TIS register block top level
// Connects the bus port, locality arbiter, interrupt control and command FIFO
`timescale 1ns/1ps

module tisRegs (
  input  logic                          clk_i,
  input  logic                          rstN_i,
  // Host side
  input  logic                          dataReq_i,
  input  logic                          dataWr_i,
  input  logic [15:0]                   addr_i,
  input  logic [7:0]                    data_i,
  output logic [7:0]                    data_o,
  output logic                          dataRd_o,
  output logic                          wrDone_o,
  output logic [3:0]                    irqNum_o,
  output logic                          interrupt_o,
  // MCU side
  output logic                          exec_o,
  input  logic                          complete_i,
  output logic                          abort_o,
  // RAM side
  output logic [tisPkg::RAM_ADDR_W-1:0] ramAddr_o,
  input  logic [7:0]                    ramRdData_i,
  output logic [7:0]                    ramWrData_o,
  output logic                          ramWr_o,
  output logic                          ramRd_o
);
  import tisPkg::*;

  busReq_t    busReq;
  logic [3:0] activeLocality;
  logic       localityMatch;
  logic [7:0] accessRd;
  logic [7:0] intRd;
  logic [7:0] cmdRd;
  logic       localityChange;
  logic       cmdAbort;
  logic       dataAvailSet;

  tisBusPort u_busPort (
    .clk_i, .rstN_i, .dataReq_i, .dataWr_i, .addr_i, .data_i,
    .accessRd_i (accessRd),
    .intRd_i    (intRd),
    .cmdRd_i    (cmdRd),
    .req_o      (busReq),
    .data_o, .dataRd_o, .wrDone_o
  );

  tisLocalityArb u_localityArb (
    .clk_i, .rstN_i,
    .req_i            (busReq),
    .activeLocality_o (activeLocality),
    .localityMatch_o  (localityMatch),
    .accessRd_o       (accessRd),
    .localityChange_o (localityChange),
    .cmdAbort_o       (cmdAbort)
  );

  tisIntCtrl u_intCtrl (
    .clk_i, .rstN_i,
    .req_i            (busReq),
    .localityMatch_i  (localityMatch),
    .localityChange_i (localityChange),
    .dataAvailSet_i   (dataAvailSet),
    .intRd_o          (intRd),
    .irqNum_o, .interrupt_o
  );

  tisCmdFifo u_cmdFifo (
    .clk_i, .rstN_i,
    .req_i           (busReq),
    .localityMatch_i (localityMatch),
    .cmdAbort_i      (cmdAbort),
    .cmdRd_o         (cmdRd),
    .dataAvailSet_o  (dataAvailSet),
    .exec_o, .complete_i, .abort_o,
    .ramAddr_o, .ramRdData_i, .ramWrData_o, .ramWr_o, .ramRd_o
  );

endmodule

/* sim/tisRegs_chk.sv */
// TIS register block checker
// Concurrent rules on the host handshake, the RAM strobe and the MCU signals
`timescale 1ns/1ps

module tisRegs_chk (
  input logic clk_i,
  input logic rstN_i,
  input logic dataWr_i,
  input logic wrDone_o,
  input logic ramWr_o,
  input logic ramRd_o,
  input logic exec_o,
  input logic abort_o
);

  int assertFails = 0;  // Summed into the testbench summary

  wrDoneNeedsWrite: assert property (@(posedge clk_i) disable iff (!rstN_i)
    $rose(wrDone_o) |-> $past(dataWr_i))
    else begin
      $error("wrDone_o rose without dataWr_i");
      assertFails++;
    end

  // One RAM write per FIFO byte
  ramWrSingle: assert property (@(posedge clk_i) disable iff (!rstN_i)
    ramWr_o |=> !ramWr_o)
    else begin
      $error("ramWr_o high for two cycles");
      assertFails++;
    end

  execAbortExclusive: assert property (@(posedge clk_i) disable iff (!rstN_i)
    !(exec_o && abort_o))
    else begin
      $error("exec_o and abort_o high together");
      assertFails++;
    end

  ramRdInverse: assert property (@(posedge clk_i) disable iff (!rstN_i)
    ramRd_o != ramWr_o)
    else begin
      $error("ramRd_o is not the inverse of ramWr_o");
      assertFails++;
    end

endmodule

bind tisRegs tisRegs_chk u_chk (.*);

/* sim/tisRegs_tb.sv */
// TIS register block testbench
// Host handshake driver, RAM and MCU models, directed tests and a summary
`timescale 1ns/1ps

module tisRegs_tb;
  import tisPkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int XFER_BUDGET = 250;       // Upper bound on host handshakes over all tests
  localparam logic [3:0] IRQ_VECTOR = 4'h5;

  logic        clk_i;
  logic        rstN_i;
  logic        dataReq_i;
  logic        dataWr_i;
  logic [15:0] addr_i;
  logic [7:0]  data_i;
  logic [7:0]  data_o;
  logic        dataRd_o;
  logic        wrDone_o;
  logic [3:0]  irqNum_o;
  logic        interrupt_o;
  logic        exec_o;
  logic        complete_i;
  logic        abort_o;
  logic [RAM_ADDR_W-1:0] ramAddr_o;
  logic [7:0]  ramRdData_i;
  logic [7:0]  ramWrData_o;
  logic        ramWr_o;
  logic        ramRd_o;

  logic [7:0]  ram [0:2**RAM_ADDR_W-1];
  logic        mcuWr;
  logic [RAM_ADDR_W-1:0] mcuAddr;
  logic [7:0]  mcuData;
  logic [7:0]  cmdBytes [0:63];
  logic [7:0]  respBytes [0:63];
  logic [31:0] lfsr = 32'h99ad_c525;
  int          checks = 0;
  int          errors = 0;
  int          assertFails;
  string       waitingFor = "reset";

  tisRegs u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Model RAM, filled during reset, then written by the DUT or the MCU
  assign ramRdData_i = ram[ramAddr_o];
  always @(posedge clk_i) begin
    if (!rstN_i) begin
      for (int a = 0; a < 2**RAM_ADDR_W; a++) ram[a] <= 8'(a) ^ 8'(a >> 3) ^ 8'h5A;
    end else if (ramWr_o) begin
      ram[ramAddr_o] <= ramWrData_o;
    end else if (mcuWr) begin
      ram[mcuAddr] <= mcuData;
    end
  end

  function automatic logic [7:0] nextByte();
    logic [7:0] b;
    b = 8'h00;
    for (int k = 0; k < 8; k++) begin  // One LFSR step per bit
      b    = {lfsr[0], b[7:1]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return b;
  endfunction

  // TPM frame, tag and body random, bytes 2 to 5 the big-endian size
  function automatic logic [7:0] frameByte(input int idx, input int len);
    logic [31:0] size;
    size = 32'(len);
    case (idx)
      2:       return size[31:24];
      3:       return size[23:16];
      4:       return size[15:8];
      5:       return size[7:0];
      default: return nextByte();
    endcase
  endfunction

  function automatic logic [15:0] regAddr(input logic [3:0] loc, input logic [11:0] ofs);
    return {loc, ofs};
  endfunction

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic hostWrite(input logic [15:0] a, input logic [7:0] d);
    @(posedge clk_i);
    addr_i   <= a;
    data_i   <= d;
    dataWr_i <= 1'b1;
    waitingFor = "wrDone_o high";
    do @(posedge clk_i); while (!wrDone_o);
    dataWr_i <= 1'b0;
    waitingFor = "wrDone_o low";
    do @(posedge clk_i); while (wrDone_o);
  endtask

  task automatic hostRead(input logic [15:0] a, output logic [7:0] d);
    @(posedge clk_i);
    addr_i    <= a;
    dataReq_i <= 1'b1;
    waitingFor = "dataRd_o high";
    do @(posedge clk_i); while (!dataRd_o);
    d = data_o;
    dataReq_i <= 1'b0;
    waitingFor = "dataRd_o low";
    do @(posedge clk_i); while (dataRd_o);
  endtask

  task automatic readCheck(input logic [15:0] a, input logic [7:0] exp, input string what);
    logic [7:0] got;
    hostRead(a, got);
    checkEq(got, exp, what);
  endtask

  task automatic checkReset();
    checkEq(data_o, 8'hFF, "data_o after reset");
    checkEq(dataRd_o, 1'b0, "dataRd_o after reset");
    checkEq(wrDone_o, 1'b0, "wrDone_o after reset");
    checkEq(ramWr_o, 1'b0, "ramWr_o after reset");
    checkEq(ramRd_o, 1'b1, "ramRd_o after reset");
    checkEq(exec_o, 1'b0, "exec_o after reset");
    checkEq(abort_o, 1'b0, "abort_o after reset");
    checkEq(interrupt_o, 1'b0, "interrupt_o after reset");
    readCheck(regAddr(0, REG_OFS_ACCESS), 8'h80, "ACCESS of locality 0 after reset");
    readCheck(regAddr(5, REG_OFS_ACCESS), 8'hFF, "ACCESS of locality 5");
    readCheck(regAddr(5, REG_OFS_STS), 8'hFF, "STS of locality 5");
  endtask

  task automatic checkArbitration();
    hostWrite(regAddr(0, REG_OFS_ACCESS), 8'h02);
    readCheck(regAddr(0, REG_OFS_ACCESS), 8'hA0, "locality 0 active after requestUse");
    hostWrite(regAddr(2, REG_OFS_ACCESS), 8'h02);
    readCheck(regAddr(2, REG_OFS_ACCESS), 8'h82, "locality 2 requestUse");
    readCheck(regAddr(0, REG_OFS_ACCESS), 8'hA4, "locality 0 sees pendingRequest");
    hostWrite(regAddr(0, REG_OFS_ACCESS), 8'h20);  // Relinquish
    readCheck(regAddr(2, REG_OFS_ACCESS), 8'hA0, "locality 2 active after hand-over");
    readCheck(regAddr(0, REG_OFS_ACCESS), 8'h80, "locality 0 inactive after relinquish");
    hostWrite(regAddr(4, REG_OFS_ACCESS), 8'h08);  // Seize
    readCheck(regAddr(4, REG_OFS_ACCESS), 8'hA0, "locality 4 active after seize");
    readCheck(regAddr(2, REG_OFS_ACCESS), 8'h90, "locality 2 beenSeized");
    hostWrite(regAddr(2, REG_OFS_ACCESS), 8'h10);
    readCheck(regAddr(2, REG_OFS_ACCESS), 8'h80, "locality 2 beenSeized cleared");
  endtask

  task automatic setupInterrupts(input logic [3:0] loc);
    hostWrite(regAddr(loc, REG_OFS_INT_VECTOR), {4'h0, IRQ_VECTOR});
    hostWrite(regAddr(loc, REG_OFS_INT_ENABLE), 8'h05);  // dataAvail and localityChange
    hostWrite(regAddr(loc, REG_OFS_INT_ENABLE + 12'd3), 8'h80);
    readCheck(regAddr(loc, REG_OFS_INT_VECTOR), {4'h0, IRQ_VECTOR}, "INT_VECTOR readback");
    readCheck(regAddr(loc, REG_OFS_INT_ENABLE + 12'd3), 8'h80, "global enable readback");
    readCheck(regAddr(loc, REG_OFS_INT_STATUS), 8'h00, "INT_STATUS idle");
    checkEq(interrupt_o, 1'b0, "interrupt_o with no event");
  endtask

  task automatic sendCommand(input logic [3:0] loc, input int n);
    logic [15:0] sts;
    logic [15:0] fifo;
    sts  = regAddr(loc, REG_OFS_STS);
    fifo = regAddr(loc, REG_OFS_DATA_FIFO);
    for (int i = 0; i < n; i++) cmdBytes[i] = frameByte(i, n);
    hostWrite(sts, 8'h40);
    readCheck(sts, 8'hC8, "STS after commandReady");
    for (int i = 0; i < n - 1; i++) hostWrite(fifo, cmdBytes[i]);
    readCheck(sts, 8'h88, "STS expect before last byte");
    hostWrite(fifo, cmdBytes[n-1]);
    readCheck(sts, 8'h80, "STS expect clear after last byte");
    hostWrite(sts, 8'h20);  // tpmGo
    checkEq(exec_o, 1'b1, "exec_o after tpmGo");
  endtask

  task automatic mcuServe(input int n, input int m);
    waitingFor = "exec_o high";
    while (!exec_o) @(posedge clk_i);
    for (int i = 0; i < n; i++)
      checkEq(ram[i], cmdBytes[i], $sformatf("command byte %0d in RAM", i));
    for (int i = 0; i < m; i++) respBytes[i] = frameByte(i, m);
    for (int i = 0; i < m; i++) begin
      @(posedge clk_i);
      mcuWr   <= 1'b1;
      mcuAddr <= RAM_ADDR_W'(i);
      mcuData <= respBytes[i];
    end
    @(posedge clk_i);
    mcuWr      <= 1'b0;
    complete_i <= 1'b1;
    waitingFor = "exec_o low after complete_i";
    do @(posedge clk_i); while (exec_o);
    complete_i <= 1'b0;
  endtask

  task automatic checkResponse(input logic [3:0] loc, input int m);
    logic [15:0] sts;
    logic [15:0] fifo;
    sts  = regAddr(loc, REG_OFS_STS);
    fifo = regAddr(loc, REG_OFS_DATA_FIFO);
    checkEq(exec_o, 1'b0, "exec_o after complete");
    readCheck(sts, 8'h90, "STS dataAvail after complete");
    checkEq(interrupt_o, 1'b1, "interrupt_o on dataAvail");
    checkEq(irqNum_o, IRQ_VECTOR, "irqNum_o");
    readCheck(regAddr(loc, REG_OFS_INT_STATUS), 8'h01, "INT_STATUS dataAvail");
    hostWrite(regAddr(loc, REG_OFS_INT_STATUS), 8'h01);
    checkEq(interrupt_o, 1'b0, "interrupt_o after status clear");
    for (int pass = 0; pass < 2; pass++) begin
      if (pass == 1) begin
        hostWrite(sts, 8'h02);  // responseRetry
        readCheck(sts, 8'h90, "STS dataAvail after responseRetry");
        checkEq(interrupt_o, 1'b1, "interrupt_o on responseRetry");
      end
      for (int i = 0; i < m; i++)
        readCheck(fifo, respBytes[i], $sformatf("response byte %0d pass %0d", i, pass));
      readCheck(sts, 8'h80, "STS after last response byte");
      readCheck(fifo, 8'hFF, "FIFO read without dataAvail");
    end
    hostWrite(regAddr(loc, REG_OFS_INT_STATUS), 8'h01);  // Retry set the status again
    checkEq(interrupt_o, 1'b0, "interrupt_o after second clear");
  endtask

  task automatic checkAbort(input logic [3:0] loc, input int n);
    logic [15:0] sts;
    sts = regAddr(loc, REG_OFS_STS);
    hostWrite(sts, 8'h40);  // Leaves TX_LAST without an abort
    checkEq(abort_o, 1'b0, "abort_o after commandReady in TX_LAST");
    readCheck(sts, 8'h80, "STS idle after response");
    sendCommand(loc, n);
    hostWrite(sts, 8'h40);
    checkEq(abort_o, 1'b1, "abort_o after commandReady in EXEC");
    checkEq(exec_o, 1'b0, "exec_o after abort");
    readCheck(sts, 8'h80, "STS idle after abort");
    hostWrite(sts, 8'h40);
    checkEq(abort_o, 1'b0, "abort_o after next commandReady");
    readCheck(sts, 8'hC8, "STS ready after abort");
  endtask

  task automatic checkLocalityChange();
    hostWrite(regAddr(1, REG_OFS_ACCESS), 8'h02);
    readCheck(regAddr(4, REG_OFS_ACCESS), 8'hA4, "locality 4 sees pendingRequest");
    checkEq(interrupt_o, 1'b0, "interrupt_o before hand-over");
    hostWrite(regAddr(4, REG_OFS_ACCESS), 8'h20);
    readCheck(regAddr(1, REG_OFS_ACCESS), 8'hA0, "locality 1 active after hand-over");
    checkEq(interrupt_o, 1'b1, "interrupt_o on localityChange");
    readCheck(regAddr(1, REG_OFS_INT_STATUS), 8'h04, "INT_STATUS localityChange");
    hostWrite(regAddr(1, REG_OFS_INT_STATUS), 8'h04);
    checkEq(interrupt_o, 1'b0, "interrupt_o after localityChange clear");
  endtask

  // Watchdog sized from the handshake budget
  initial begin
    #(200 * XFER_BUDGET * CLK_PERIOD);
    $display("Watchdog expired while waiting for %s", waitingFor);
    $display("sim failed");
    $finish;
  end

  initial begin
    int cmdLen;
    int respLen;
    rstN_i     = 1'b0;
    dataReq_i  = 1'b0;
    dataWr_i   = 1'b0;
    addr_i     = 16'h0000;
    data_i     = 8'h00;
    complete_i = 1'b0;
    mcuWr      = 1'b0;
    mcuAddr    = '0;
    mcuData    = 8'h00;
    repeat (4) @(posedge clk_i);
    rstN_i <= 1'b1;
    @(posedge clk_i);
    checkReset();
    checkArbitration();
    setupInterrupts(4'd4);
    cmdLen  = 7 + int'(nextByte()) % 34;
    respLen = 7 + int'(nextByte()) % 34;
    sendCommand(4'd4, cmdLen);
    mcuServe(cmdLen, respLen);
    checkResponse(4'd4, respLen);
    checkAbort(4'd4, 7 + int'(nextByte()) % 34);
    checkLocalityChange();
    assertFails = u_dut.u_chk.assertFails;
    $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/tisPkg.sv
src/tisBusPort.sv
src/tisLocalityArb.sv
src/tisIntCtrl.sv
src/tisCmdFifo.sv
src/tisRegs.sv
sim/tisRegs_chk.sv
sim/tisRegs_tb.sv

/* Makefile */
TOP = tisRegs_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
